/* compile.f */
logic/sys_ctl_pkg.sv
logic/int_latch.sv
logic/idt_fetch.sv
logic/return_seq.sv
logic/redirect_arbiter.sv
logic/sys_ctl_top.sv
sim/sys_ctl_assertions.sv
sim/sys_ctl_tb.sv

/* logic/idt_fetch.sv */
`timescale 1ns/10ps

module idt_fetch
  import sys_ctl_pkg::*;
(
  input  logic              or_int_vec,
  input  logic              rst_n,
  input  logic              any_pending,
  input  logic [vec_w-1:0]  top_vec,
  input  logic              hold_int,
  input  logic              mem_ready,
  input  logic              mem_dp_valid,
  input  logic [addr_w-1:0] mem_dp_read_data,
  input  logic              int_grant,
  output logic              mem_valid,
  output logic [addr_w-1:0] mem_address,
  output logic              mem_dp_ready,
  output logic              int_req,
  output logic [addr_w-1:0] int_target,
  output logic [sel_w-1:0]  int_sel,
  output logic              clear,
  output logic [vec_w-1:0]  clear_vec
);

  logic [idt_state_w-1:0] state_q;
  logic [vec_w-1:0]       vec_q;
  logic [sel_w-1:0]       off_lo_q;
  logic [sel_w-1:0]       off_hi_q;
  logic [sel_w-1:0]       sel_q;
  gate_word_u             swap_w;

  // table is stored big endian
  assign swap_w.raw = {mem_dp_read_data[7:0], mem_dp_read_data[15:8],
                       mem_dp_read_data[23:16], mem_dp_read_data[31:24]};

  ////////////////////
  // gate read FSM

  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      state_q <= is_idle;
    end else begin
      case (state_q)
        is_idle: begin
          if (any_pending && !hold_int) begin
            state_q <= is_req0;
          end
        end
        is_req0: begin
          if (mem_ready) begin
            state_q <= is_resp0;
          end
        end
        is_resp0: begin
          if (mem_dp_valid) begin
            state_q <= is_req1;
          end
        end
        is_req1: begin
          if (mem_ready) begin
            state_q <= is_resp1;
          end
        end
        is_resp1: begin
          if (mem_dp_valid) begin
            state_q <= is_grant;
          end
        end
        is_grant: begin
          if (int_grant) begin
            state_q <= is_idle;
          end
        end
        default: state_q <= is_idle;
      endcase
    end
  end

  // vector and gate halves
  always_ff @(posedge or_int_vec) begin
    if (state_q == is_idle && any_pending && !hold_int) begin
      vec_q <= top_vec;
    end
    if (state_q == is_resp0 && mem_dp_valid) begin
      off_lo_q <= swap_w.half[0];
    end
    if (state_q == is_resp1 && mem_dp_valid) begin
      sel_q    <= swap_w.half[1];
      off_hi_q <= swap_w.half[0];
    end
  end

  ////////////////////
  // bus and redirect outputs

  assign mem_valid    = (state_q == is_req0) || (state_q == is_req1);
  assign mem_dp_ready = (state_q == is_resp0) || (state_q == is_resp1);
  assign mem_address  = gate_addr[vec_q] + ((state_q == is_req1) ? addr_w'(4) : addr_w'(0));

  assign int_req    = (state_q == is_grant);
  assign int_target = {off_hi_q, off_lo_q};
  assign int_sel    = sel_q;

  // pending bit drops on the same edge the FSM goes idle
  assign clear     = int_req & int_grant;
  assign clear_vec = vec_q;

endmodule

/* logic/int_latch.sv */
`timescale 1ns/10ps

module int_latch
  import sys_ctl_pkg::*;
(
  input  logic             or_int_vec,
  input  logic             rst_n,
  input  logic [vec_n-1:0] int_vec,
  input  logic             clear,
  input  logic [vec_w-1:0] clear_vec,
  output logic             any_pending,
  output logic [vec_w-1:0] top_vec,
  output logic             pending_int
);

  logic [vec_n-1:0] pending_q;
  logic [vec_n-1:0] clr_mask;
  logic [vec_n-1:0] pending_nxt;

  ////////////////////
  // sticky request bits

  // new requests are merged first, then the serviced line is knocked out
  always_comb begin
    clr_mask    = clear ? (vec_n'(1) << clear_vec) : '0;
    pending_nxt = (pending_q | int_vec) & ~clr_mask;
  end

  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_nxt;
    end
  end

  ////////////////////
  // lowest index wins

  always_comb begin
    top_vec = '0;
    for (int i = vec_n - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        top_vec = vec_w'(i);
      end
    end
  end

  assign any_pending = |pending_q;
  assign pending_int = any_pending;

endmodule

/* logic/redirect_arbiter.sv */
`timescale 1ns/10ps

module redirect_arbiter
  import sys_ctl_pkg::*;
(
  input  logic              or_int_vec,
  input  logic              rst_n,
  input  logic              jump_load,
  input  logic [addr_w-1:0] jump_load_address,
  input  logic              jump_load_cs,
  input  logic [sel_w-1:0]  jump_cs,
  input  logic              ret_req,
  input  logic [addr_w-1:0] ret_target,
  input  logic [sel_w-1:0]  ret_sel,
  input  logic              ret_sel_load,
  input  logic              iretd_halt,
  input  logic              int_req,
  input  logic [addr_w-1:0] int_target,
  input  logic [sel_w-1:0]  int_sel,
  output logic              ret_grant,
  output logic              int_grant,
  output logic              fetch_load,
  output logic [addr_w-1:0] fetch_load_address,
  output logic              reg_load_cs,
  output logic [sel_w-1:0]  reg_cs,
  output logic              flush_fetch,
  output logic              flush_decode_0,
  output logic              flush_decode_1,
  output logic              flush_register,
  output logic              flush_address,
  output logic              flush_execute
);

  logic               jmp_q;
  logic [addr_w-1:0]  jmp_addr_q;
  logic               jmp_cs_load_q;
  logic [sel_w-1:0]   jmp_cs_q;
  logic [addr_w-1:0]  nxt_addr;
  logic [sel_w-1:0]   nxt_cs;
  logic               nxt_cs_load;
  logic [flush_n-1:0] nxt_flush;
  logic [flush_n-1:0] flush_q;

  ////////////////////
  // jump capture

  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      jmp_q <= 1'b0;
    end else begin
      jmp_q <= jump_load;
    end
  end

  always_ff @(posedge or_int_vec) begin
    jmp_addr_q    <= jump_load_address;
    jmp_cs_load_q <= jump_load_cs;
    jmp_cs_q      <= jump_cs;
  end

  ////////////////////
  // fixed priority: jump, return, interrupt

  assign ret_grant = ret_req & ~jmp_q;
  assign int_grant = int_req & ~jmp_q & ~ret_req;

  always_comb begin
    nxt_addr    = int_target;
    nxt_cs      = int_sel;
    nxt_cs_load = int_grant;
    nxt_flush   = int_grant ? '1 : '0;
    if (jmp_q) begin
      nxt_addr    = jmp_addr_q;
      nxt_cs      = jmp_cs_q;
      nxt_cs_load = jmp_cs_load_q;
      nxt_flush   = '1;
    end else if (ret_grant) begin
      nxt_addr    = ret_target;
      nxt_cs      = ret_sel;
      nxt_cs_load = ret_sel_load;
      nxt_flush   = '0;
      nxt_flush[fl_fetch] = 1'b1;
    end
  end

  ////////////////////
  // registered redirect

  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      fetch_load  <= 1'b0;
      reg_load_cs <= 1'b0;
      flush_q     <= '0;
    end else begin
      fetch_load  <= jmp_q | ret_grant | int_grant;
      reg_load_cs <= nxt_cs_load;
      flush_q     <= nxt_flush;
    end
  end

  always_ff @(posedge or_int_vec) begin
    fetch_load_address <= nxt_addr;
    reg_cs             <= nxt_cs;
  end

  // fetch also stays flushed for the whole pop sequence
  assign flush_fetch    = flush_q[fl_fetch] | iretd_halt;
  assign flush_decode_0 = flush_q[fl_decode_0];
  assign flush_decode_1 = flush_q[fl_decode_1];
  assign flush_register = flush_q[fl_register];
  assign flush_address  = flush_q[fl_address];
  assign flush_execute  = flush_q[fl_execute];

endmodule

/* logic/return_seq.sv */
`timescale 1ns/10ps

module return_seq
  import sys_ctl_pkg::*;
(
  input  logic              or_int_vec,
  input  logic              rst_n,
  input  logic              iretd,
  input  logic              ret_far,
  input  logic              ret_near,
  input  logic              iretd_pop_valid,
  input  logic [addr_w-1:0] iretd_pop_data,
  input  logic              ret_grant,
  output logic              iretd_halt,
  output logic              reg_load_eflags,
  output logic [addr_w-1:0] reg_eflags,
  output logic              reg_load_eip,
  output logic [addr_w-1:0] reg_eip,
  output logic              ret_req,
  output logic [addr_w-1:0] ret_target,
  output logic [sel_w-1:0]  ret_sel,
  output logic              ret_sel_load
);

  logic [ret_state_w-1:0] state_q;
  logic [addr_w-1:0]      target_q;
  logic [sel_w-1:0]       sel_q;
  logic                   sel_load_q;

  ////////////////////
  // pop sequencing

  // iretd pops eflags, cs, eip; far skips eflags; near pops eip only
  always_ff @(posedge or_int_vec) begin
    if (!rst_n) begin
      state_q    <= rs_idle;
      sel_load_q <= 1'b0;
    end else begin
      case (state_q)
        rs_idle: begin
          sel_load_q <= 1'b0;
          if (iretd) begin
            state_q <= rs_eflags;
          end else if (ret_far) begin
            state_q <= rs_sel;
          end else if (ret_near) begin
            state_q <= rs_eip;
          end
        end
        rs_eflags: begin
          if (iretd_pop_valid) begin
            state_q <= rs_sel;
          end
        end
        rs_sel: begin
          if (iretd_pop_valid) begin
            state_q    <= rs_eip;
            sel_load_q <= 1'b1;
          end
        end
        rs_eip: begin
          if (iretd_pop_valid) begin
            state_q <= rs_grant;
          end
        end
        rs_grant: begin
          if (ret_grant) begin
            state_q <= rs_idle;
          end
        end
        default: state_q <= rs_idle;
      endcase
    end
  end

  always_ff @(posedge or_int_vec) begin
    if (state_q == rs_sel && iretd_pop_valid) begin
      sel_q <= iretd_pop_data[sel_w-1:0];
    end
    if (state_q == rs_eip && iretd_pop_valid) begin
      target_q <= iretd_pop_data;
    end
  end

  ////////////////////
  // outputs

  assign iretd_halt = (state_q != rs_idle);

  assign reg_load_eflags = iretd_pop_valid && (state_q == rs_eflags);
  assign reg_eflags      = iretd_pop_data;
  assign reg_load_eip    = iretd_pop_valid && (state_q == rs_eip);
  assign reg_eip         = iretd_pop_data;

  assign ret_req      = (state_q == rs_grant);
  assign ret_target   = target_q;
  assign ret_sel      = sel_q;
  assign ret_sel_load = sel_load_q;

endmodule

/* logic/sys_ctl_pkg.sv */
package sys_ctl_pkg;

  localparam int addr_w      = 32;
  localparam int sel_w       = 16;
  localparam int vec_n       = 16;
  localparam int vec_w       = 4;
  localparam int ret_state_w = 3;
  localparam int idt_state_w = 3;
  localparam int flush_n     = 6;

  // flush line positions
  localparam logic [2:0] fl_fetch    = 3'd0;
  localparam logic [2:0] fl_decode_0 = 3'd1;
  localparam logic [2:0] fl_decode_1 = 3'd2;
  localparam logic [2:0] fl_register = 3'd3;
  localparam logic [2:0] fl_address  = 3'd4;
  localparam logic [2:0] fl_execute  = 3'd5;

  // gate table, first word of each vector; second word sits 4 above
  localparam logic [addr_w-1:0] gate_addr [vec_n] = '{
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_f000, 32'h0000_f000, 32'h0000_f000, 32'h0000_f000,
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_0100, 32'h0000_f000, 32'h0000_f000, 32'h0000_f000
  };

  // gate read states
  localparam logic [idt_state_w-1:0] is_idle  = 3'd0;
  localparam logic [idt_state_w-1:0] is_req0  = 3'd1;
  localparam logic [idt_state_w-1:0] is_resp0 = 3'd2;
  localparam logic [idt_state_w-1:0] is_req1  = 3'd3;
  localparam logic [idt_state_w-1:0] is_resp1 = 3'd4;
  localparam logic [idt_state_w-1:0] is_grant = 3'd5;

  // return pop states
  localparam logic [ret_state_w-1:0] rs_idle   = 3'd0;
  localparam logic [ret_state_w-1:0] rs_eflags = 3'd1;
  localparam logic [ret_state_w-1:0] rs_sel    = 3'd2;
  localparam logic [ret_state_w-1:0] rs_eip    = 3'd3;
  localparam logic [ret_state_w-1:0] rs_grant  = 3'd4;

  // half[1] is the high half, half[0] the low half
  typedef union packed {
    logic [addr_w-1:0]       raw;
    logic [1:0][sel_w-1:0]   half;
  } gate_word_u;

endpackage

/* logic/sys_ctl_top.sv */
`timescale 1ns/10ps

module sys_ctl_top
  import sys_ctl_pkg::*;
(
  input  logic              or_int_vec,
  input  logic              rst_n,
  input  logic [vec_n-1:0]  int_vec,
  input  logic              hold_int,
  output logic              pending_int,
  output logic              mem_valid,
  input  logic              mem_ready,
  output logic [addr_w-1:0] mem_address,
  input  logic              mem_dp_valid,
  output logic              mem_dp_ready,
  input  logic [addr_w-1:0] mem_dp_read_data,
  input  logic              iretd,
  input  logic              ret_far,
  input  logic              ret_near,
  output logic              iretd_halt,
  input  logic              iretd_pop_valid,
  input  logic [addr_w-1:0] iretd_pop_data,
  output logic              reg_load_eflags,
  output logic [addr_w-1:0] reg_eflags,
  output logic              reg_load_eip,
  output logic [addr_w-1:0] reg_eip,
  input  logic              jump_load,
  input  logic [addr_w-1:0] jump_load_address,
  input  logic              jump_load_cs,
  input  logic [sel_w-1:0]  jump_cs,
  output logic              fetch_load,
  output logic [addr_w-1:0] fetch_load_address,
  output logic              reg_load_cs,
  output logic [sel_w-1:0]  reg_cs,
  output logic              flush_fetch,
  output logic              flush_decode_0,
  output logic              flush_decode_1,
  output logic              flush_register,
  output logic              flush_address,
  output logic              flush_execute
);

  logic              any_pending;
  logic [vec_w-1:0]  top_vec;
  logic              clear;
  logic [vec_w-1:0]  clear_vec;
  logic              int_req;
  logic              int_grant;
  logic [addr_w-1:0] int_target;
  logic [sel_w-1:0]  int_sel;
  logic              ret_req;
  logic              ret_grant;
  logic [addr_w-1:0] ret_target;
  logic [sel_w-1:0]  ret_sel;
  logic              ret_sel_load;

  int_latch int_latch_i (
    .or_int_vec  (or_int_vec),
    .rst_n       (rst_n),
    .int_vec     (int_vec),
    .clear       (clear),
    .clear_vec   (clear_vec),
    .any_pending (any_pending),
    .top_vec     (top_vec),
    .pending_int (pending_int)
  );

  idt_fetch idt_fetch_i (
    .or_int_vec       (or_int_vec),
    .rst_n            (rst_n),
    .any_pending      (any_pending),
    .top_vec          (top_vec),
    .hold_int         (hold_int),
    .mem_ready        (mem_ready),
    .mem_dp_valid     (mem_dp_valid),
    .mem_dp_read_data (mem_dp_read_data),
    .int_grant        (int_grant),
    .mem_valid        (mem_valid),
    .mem_address      (mem_address),
    .mem_dp_ready     (mem_dp_ready),
    .int_req          (int_req),
    .int_target       (int_target),
    .int_sel          (int_sel),
    .clear            (clear),
    .clear_vec        (clear_vec)
  );

  return_seq return_seq_i (
    .or_int_vec      (or_int_vec),
    .rst_n           (rst_n),
    .iretd           (iretd),
    .ret_far         (ret_far),
    .ret_near        (ret_near),
    .iretd_pop_valid (iretd_pop_valid),
    .iretd_pop_data  (iretd_pop_data),
    .ret_grant       (ret_grant),
    .iretd_halt      (iretd_halt),
    .reg_load_eflags (reg_load_eflags),
    .reg_eflags      (reg_eflags),
    .reg_load_eip    (reg_load_eip),
    .reg_eip         (reg_eip),
    .ret_req         (ret_req),
    .ret_target      (ret_target),
    .ret_sel         (ret_sel),
    .ret_sel_load    (ret_sel_load)
  );

  redirect_arbiter redirect_arbiter_i (
    .or_int_vec         (or_int_vec),
    .rst_n              (rst_n),
    .jump_load          (jump_load),
    .jump_load_address  (jump_load_address),
    .jump_load_cs       (jump_load_cs),
    .jump_cs            (jump_cs),
    .ret_req            (ret_req),
    .ret_target         (ret_target),
    .ret_sel            (ret_sel),
    .ret_sel_load       (ret_sel_load),
    .iretd_halt         (iretd_halt),
    .int_req            (int_req),
    .int_target         (int_target),
    .int_sel            (int_sel),
    .ret_grant          (ret_grant),
    .int_grant          (int_grant),
    .fetch_load         (fetch_load),
    .fetch_load_address (fetch_load_address),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .flush_fetch        (flush_fetch),
    .flush_decode_0     (flush_decode_0),
    .flush_decode_1     (flush_decode_1),
    .flush_register     (flush_register),
    .flush_address      (flush_address),
    .flush_execute      (flush_execute)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the system control testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module sys_ctl_tb \
  -Mdir obj_dir \
  -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit $status
fi

./obj_dir/Vsys_ctl_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0

/* sim/sys_ctl_assertions.sv */
`timescale 1ns/10ps

module sys_ctl_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        mem_valid,
  input logic        mem_ready,
  input logic [31:0] mem_address,
  input logic        ret_grant,
  input logic        int_grant,
  input logic        fetch_load,
  input logic        flush_fetch
);

  // request held with a steady address until the memory takes it
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_address))
    else $error("memory request dropped or moved before mem_ready");

  // a granted source drops its request, so each redirect is a single pulse
  a_ret_once: assert property (@(posedge clk) disable iff (!rst_n)
    ret_grant |=> !ret_grant)
    else $error("return granted in two cycles running");

  a_int_once: assert property (@(posedge clk) disable iff (!rst_n)
    int_grant |=> !int_grant)
    else $error("interrupt granted in two cycles running");

  a_fetch_flush: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_load |-> flush_fetch)
    else $error("fetch_load without flush_fetch");

endmodule

bind idt_fetch sys_ctl_assertions idt_chk_i (
  .clk         (or_int_vec),
  .rst_n       (rst_n),
  .mem_valid   (mem_valid),
  .mem_ready   (mem_ready),
  .mem_address (mem_address),
  .ret_grant   (1'b0),
  .int_grant   (int_grant),
  .fetch_load  (1'b0),
  .flush_fetch (1'b1)
);

bind redirect_arbiter sys_ctl_assertions arb_chk_i (
  .clk         (or_int_vec),
  .rst_n       (rst_n),
  .mem_valid   (1'b0),
  .mem_ready   (1'b0),
  .mem_address (32'h0),
  .ret_grant   (ret_grant),
  .int_grant   (int_grant),
  .fetch_load  (fetch_load),
  .flush_fetch (flush_fetch)
);

/* sim/sys_ctl_tb.sv */
`timescale 1ns/10ps

module sys_ctl_tb
  import sys_ctl_pkg::*;
;

  logic or_int_vec = 1'b0;
  logic rst_n;
  logic [vec_n-1:0] int_vec;
  logic hold_int, mem_ready, mem_dp_valid, iretd, ret_far, ret_near, iretd_pop_valid;
  logic [addr_w-1:0] mem_dp_read_data, iretd_pop_data, jump_load_address;
  logic jump_load, jump_load_cs;
  logic [sel_w-1:0] jump_cs;
  logic pending_int, mem_valid, mem_dp_ready, iretd_halt, reg_load_eflags, reg_load_eip;
  logic [addr_w-1:0] mem_address, reg_eflags, reg_eip, fetch_load_address;
  logic fetch_load, reg_load_cs;
  logic [sel_w-1:0] reg_cs;
  logic flush_fetch, flush_decode_0, flush_decode_1, flush_register, flush_address;
  logic flush_execute;

  logic [addr_w-1:0] mem [logic [addr_w-1:0]];
  logic [addr_w-1:0] exp_addr [$];
  logic              exp_cs_load [$];
  logic [sel_w-1:0]  exp_cs [$];
  logic [5:0]        exp_flush [$];
  logic [addr_w-1:0] exp_rd [$];
  int mstate, mdelay;
  logic [addr_w-1:0] rd_addr;

  always #50 or_int_vec = ~or_int_vec;

  sys_ctl_top dut_i (.*);

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED @%0t: %s got %h expected %h",
                         $time, what, got, exp));
    end
  endtask

  // handler target in [31:0], selector in [47:32]
  function automatic logic [47:0] ref_redirect(logic [31:0] w0, logic [31:0] w1);
    gate_word_u g0;
    gate_word_u g1;
    for (int b = 0; b < 4; b++) begin
      g0.raw[8*b +: 8] = w0[8*(3-b) +: 8];
      g1.raw[8*b +: 8] = w1[8*(3-b) +: 8];
    end
    return {g1.half[1], g1.half[0], g0.half[0]};
  endfunction

  ////////////////////
  // memory model

  always @(posedge or_int_vec) begin
    if (!rst_n) begin
      mem_ready    <= 1'b0;
      mem_dp_valid <= 1'b0;
      mstate       <= 0;
      mdelay       <= 0;
    end else begin
      mem_ready    <= 1'b0;
      mem_dp_valid <= 1'b0;
      case (mstate)
        0: if (mem_valid) begin
          if (mdelay == 0) begin
            if (exp_rd.size() == 0) fail_run("unexpected gate read");
            check_value("gate read address", mem_address, exp_rd.pop_front());
            if (!mem.exists(mem_address)) fail_run("gate read outside the table");
            rd_addr   <= mem_address;
            mem_ready <= 1'b1;
            mdelay    <= $urandom_range(3, 0);
            mstate    <= 1;
          end else begin
            mdelay <= mdelay - 1;
          end
        end
        1: if (mdelay == 0) begin
          mem_dp_valid     <= 1'b1;
          mem_dp_read_data <= mem[rd_addr];
          mstate           <= 2;
        end else begin
          mdelay <= mdelay - 1;
        end
        default: begin
          if (!mem_dp_ready) fail_run("read data offered without mem_dp_ready");
          mdelay <= $urandom_range(3, 0);
          mstate <= 0;
        end
      endcase
    end
  end

  ////////////////////
  // redirect monitor

  always @(negedge or_int_vec) begin
    if (rst_n && fetch_load) begin
      if (exp_addr.size() == 0) fail_run("fetch_load with no redirect expected");
      check_value("fetch_load_address", fetch_load_address, exp_addr.pop_front());
      check_value("reg_load_cs", 32'(reg_load_cs), 32'(exp_cs_load[0]));
      if (exp_cs_load.pop_front()) check_value("reg_cs", 32'(reg_cs), 32'(exp_cs[0]));
      void'(exp_cs.pop_front());
      check_value("flush lines", 32'({flush_execute, flush_address, flush_register,
                  flush_decode_1, flush_decode_0, flush_fetch}), 32'(exp_flush.pop_front()));
    end
    if (rst_n && iretd_halt) check_value("flush_fetch during halt", 32'(flush_fetch), 32'd1);
  end

  task automatic push_redirect(logic [31:0] a, logic cl, logic [15:0] cs, logic [5:0] fl);
    exp_addr.push_back(a);
    exp_cs_load.push_back(cl);
    exp_cs.push_back(cs);
    exp_flush.push_back(fl);
  endtask

  task automatic push_reads(int v);
    exp_rd.push_back(gate_addr[v]);
    exp_rd.push_back(gate_addr[v] + 32'd4);
  endtask

  task automatic push_int(int v);
    logic [47:0] r;
    r = ref_redirect(mem[gate_addr[v]], mem[gate_addr[v] + 32'd4]);
    push_redirect(r[31:0], 1'b1, r[47:32], 6'h3f);
  endtask

  task automatic wait_drain(string what);
    int n;
    n = 0;
    while (exp_addr.size() != 0 || exp_rd.size() != 0) begin
      @(negedge or_int_vec);
      n++;
      if (n > 500) fail_run({"timeout: no redirect arrived for ", what});
    end
  endtask

  // one cycle of lines, pending_int must rise exactly one cycle later
  task automatic raise_lines(logic [15:0] mask);
    @(posedge or_int_vec);
    int_vec <= mask;
    @(negedge or_int_vec);
    check_value("pending_int before latch", 32'(pending_int), 32'd0);
    @(posedge or_int_vec);
    int_vec <= '0;
    @(negedge or_int_vec);
    check_value("pending_int after latch", 32'(pending_int), 32'd1);
  endtask

  task automatic expect_fetch_at(int n);
    for (int i = 1; i <= n; i++) begin
      @(negedge or_int_vec);
      check_value("fetch_load timing", 32'(fetch_load), 32'(i == n));
    end
  endtask

  task automatic jump(logic [31:0] a, logic cl, logic [15:0] cs);
    @(posedge or_int_vec);
    jump_load         <= 1'b1;
    jump_load_address <= a;
    jump_load_cs      <= cl;
    jump_cs           <= cs;
    push_redirect(a, cl, cs, 6'h3f);
    @(posedge or_int_vec);
    jump_load <= 1'b0;
    expect_fetch_at(2);
  endtask

  task automatic pop(logic [31:0] d, logic ef, logic ip, logic with_jump);
    @(posedge or_int_vec);
    iretd_pop_valid <= 1'b1;
    iretd_pop_data  <= d;
    jump_load       <= with_jump;
    @(negedge or_int_vec);
    check_value("iretd_halt during pops", 32'(iretd_halt), 32'd1);
    check_value("reg_load_eflags", 32'(reg_load_eflags), 32'(ef));
    check_value("reg_load_eip", 32'(reg_load_eip), 32'(ip));
    if (ef) check_value("reg_eflags", reg_eflags, d);
    if (ip) check_value("reg_eip", reg_eip, d);
    @(posedge or_int_vec);
    iretd_pop_valid <= 1'b0;
    jump_load       <= 1'b0;
  endtask

  // kind 0 iretd, 1 far return, 2 near return
  task automatic do_return(int kind, logic with_jump);
    logic [31:0] p1, p2, p3;
    p1 = $urandom;
    p2 = $urandom;
    p3 = $urandom;
    @(posedge or_int_vec);
    iretd    <= (kind == 0);
    ret_far  <= (kind == 1);
    ret_near <= (kind == 2);
    @(posedge or_int_vec);
    {iretd, ret_far, ret_near} <= 3'b000;
    if (kind == 0) pop(p1, 1'b1, 1'b0, 1'b0);
    if (kind != 2) pop(p2, 1'b0, 1'b0, 1'b0);
    if (with_jump) begin
      jump_load_address <= 32'h0000_7700;
      jump_load_cs      <= 1'b0;
      push_redirect(32'h0000_7700, 1'b0, 16'h0, 6'h3f);
    end
    push_redirect(p3, kind != 2, p2[15:0], 6'h01);
    pop(p3, 1'b0, 1'b1, with_jump);
    if (!with_jump) expect_fetch_at(2);
    wait_drain("return");
    check_value("iretd_halt after return", 32'(iretd_halt), 32'd0);
  endtask

  initial begin
    int n;
    void'($urandom(32'h873e_6e64));
    for (int v = 0; v < vec_n; v++) begin
      mem[gate_addr[v]]         = $urandom;
      mem[gate_addr[v] + 32'd4] = $urandom;
    end
    rst_n = 1'b0;
    {int_vec, hold_int, iretd, ret_far, ret_near, iretd_pop_valid} = '0;
    {jump_load, jump_load_cs, jump_cs, jump_load_address, iretd_pop_data} = '0;
    {mem_ready, mem_dp_valid} = '0;
    mem_dp_read_data = '0;
    repeat (16) @(posedge or_int_vec);
    rst_n <= 1'b1;

    // single line
    push_reads(6);
    push_int(6);
    raise_lines(16'h0040);
    wait_drain("vector 6");
    @(negedge or_int_vec);
    check_value("pending_int after service", 32'(pending_int), 32'd0);

    // lowest index first
    push_reads(3);
    push_int(3);
    push_reads(9);
    push_int(9);
    push_reads(12);
    push_int(12);
    raise_lines(16'h1208);
    wait_drain("vectors 3, 9 and 12");

    //////////////////// held off
    @(posedge or_int_vec);
    hold_int <= 1'b1;
    raise_lines(16'h0020);
    repeat (20) begin
      @(negedge or_int_vec);
      check_value("mem_valid under hold", 32'(mem_valid), 32'd0);
      check_value("pending_int under hold", 32'(pending_int), 32'd1);
    end
    push_reads(5);
    push_int(5);
    @(posedge or_int_vec);
    hold_int <= 1'b0;
    wait_drain("vector 5 after hold");

    // returns and jumps
    do_return(0, 1'b0);
    do_return(1, 1'b0);
    do_return(2, 1'b0);
    jump(32'h1234_5678, 1'b1, 16'h0abc);
    jump(32'h0bad_f00d, 1'b0, 16'h0123);
    do_return(1, 1'b1);

    // jump lands in the middle of a gate read
    push_reads(1);
    raise_lines(16'h0002);
    n = 0;
    while (!mem_valid) begin
      @(negedge or_int_vec);
      n++;
      if (n > 100) fail_run("timeout: gate read for vector 1 never started");
    end
    jump(32'h5555_0000, 1'b1, 16'h0042);
    push_int(1);
    wait_drain("vector 1 behind a jump");

    repeat (5) @(posedge or_int_vec);
    $display("Done: no errors");
    $finish;
  end

endmodule
